/* ads_capture.sv */
`timescale 1ns/10ps

module ads_capture
	import ads_pkg::*;
#(
	parameter type T = reg_byte_t
) (
	input  logic    i2c_clk,
	input  logic    i_rst_n,
	input  i2c_rx_t i_rx,
	input  logic    i_commit,
	output T        o_value
);

	localparam int W = $bits(T);

	logic [W-1:0] shreg;
	logic [W+7:0] joined;  // new byte enters at the bottom

	assign joined = {shreg, i_rx.data};

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shreg   <= '0;
			o_value <= '0;
		end else begin
			if (i_rx.valid)
				shreg <= joined[W-1:0];
			if (i_commit)
				o_value <= shreg;  // publish assembled value
		end
	end

endmodule

/* ads_cmd_sequencer.sv */
`timescale 1ns/10ps
`include "ads_macros.svh"

module ads_cmd_sequencer
	import ads_pkg::*;
(
	input  logic        i2c_clk,
	input  logic        i_rst_n,
	input  logic [31:0] i_ctrl,
	input  logic [6:0]  i_dev_addr,
	input  logic [7:0]  i_reg_addr,
	input  logic [7:0]  i_w_data,
	input  logic        i_drdy,
	input  logic        i_done,
	input  logic        i_nack,
	output i2c_xfer_t   o_xfer,
	output logic        o_start,
	output logic        o_commit_sample,
	output logic        o_commit_reg,
	output logic [1:0]  o_chan,
	output logic        o_ready,
	output logic        o_nack
);

	typedef enum logic [2:0] {
		SQ_IDLE, SQ_ISSUE, SQ_BUSY, SQ_DRDY, SQ_NEXT
	} seq_st_e;

	typedef enum logic [2:0] {
		STEP_CPU_WR, STEP_RD_PTR, STEP_RD_DATA,
		STEP_MUX, STEP_CONV, STEP_RDATA, STEP_SAMPLE
	} step_e;

	seq_st_e    state;
	step_e      step;
	ads_mode_e  mode;
	logic       en;
	logic       en_q;
	logic       en_rise;
	logic [1:0] chan;     // scan channel, AIN0..AIN3

	assign en      = i_ctrl[`ADS_CTRL_EN_BIT];
	assign mode    = ads_mode_e'(i_ctrl[`ADS_CTRL_MODE_LSB +: 3]);
	assign en_rise = en && !en_q;
	assign o_start = (state == SQ_ISSUE);  // engine is idle here, done already seen
	assign o_ready = (state == SQ_IDLE);
	assign o_chan  = chan;

	// descriptor for the current step, latched by the engine on start
	always_comb begin
		o_xfer          = '0;
		o_xfer.dev_addr = i_dev_addr;
		case (step)
			STEP_CPU_WR: begin
				o_xfer.cmd      = i_reg_addr;
				o_xfer.data     = i_w_data;
				o_xfer.has_data = 1'b1;
			end
			STEP_RD_PTR:  o_xfer.cmd = i_reg_addr;  // pointer write only
			STEP_RD_DATA: begin
				o_xfer.rw     = 1'b1;
				o_xfer.rd_cnt = 2'd1;
			end
			STEP_MUX: begin
				o_xfer.cmd      = `ADS_CFG0_WREG;
				o_xfer.data     = `ADS_MUX_BASE + chan * `ADS_MUX_STEP;
				o_xfer.has_data = 1'b1;
			end
			STEP_CONV:  o_xfer.cmd = `ADS_CMD_START;
			STEP_RDATA: o_xfer.cmd = `ADS_CMD_RDATA;
			default: begin  // sample read
				o_xfer.rw     = 1'b1;
				o_xfer.rd_cnt = 2'(`ADS_SAMPLE_BYTES);
			end
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state           <= SQ_IDLE;
			step            <= STEP_CPU_WR;
			en_q            <= 1'b0;
			chan            <= 2'd0;
			o_commit_sample <= 1'b0;
			o_commit_reg    <= 1'b0;
			o_nack          <= 1'b0;
		end else begin
			en_q            <= en;
			o_commit_sample <= 1'b0;
			o_commit_reg    <= 1'b0;
			case (state)
				SQ_IDLE: begin
					if (en_rise && mode == MODE_CPU_WR) begin
						step   <= STEP_CPU_WR;
						state  <= SQ_ISSUE;
						o_nack <= 1'b0;
					end else if (en_rise && mode == MODE_CPU_RD) begin
						step   <= STEP_RD_PTR;
						state  <= SQ_ISSUE;
						o_nack <= 1'b0;
					end else if (en && mode == MODE_HW_SCAN) begin
						step   <= STEP_MUX;
						chan   <= 2'd0;
						state  <= SQ_ISSUE;
						o_nack <= 1'b0;
					end
				end
				SQ_ISSUE: state <= SQ_BUSY;
				SQ_BUSY: begin
					if (i_done && i_nack) begin
						o_nack <= 1'b1;  // abort whole operation
						state  <= SQ_IDLE;
					end else if (i_done) begin
						state <= SQ_ISSUE;
						case (step)
							STEP_CPU_WR: begin
								o_commit_reg <= 1'b1;  // finish only, no new byte
								state        <= SQ_IDLE;
							end
							STEP_RD_PTR: step <= STEP_RD_DATA;
							STEP_RD_DATA: begin
								o_commit_reg <= 1'b1;
								state        <= SQ_IDLE;
							end
							STEP_MUX:   step <= STEP_CONV;
							STEP_CONV:  state <= SQ_DRDY;
							STEP_RDATA: step <= STEP_SAMPLE;
							default: begin
								o_commit_sample <= 1'b1;
								state           <= SQ_NEXT;
							end
						endcase
					end
				end
				SQ_DRDY: begin
					if (!i_drdy) begin  // conversion ready
						step  <= STEP_RDATA;
						state <= SQ_ISSUE;
					end
				end
				SQ_NEXT: begin
					// chan held through the commit cycle
					chan  <= chan + 2'd1;
					step  <= STEP_MUX;
					state <= (en && mode == MODE_HW_SCAN) ? SQ_ISSUE : SQ_IDLE;
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

endmodule

/* ads_i2c_sva.sv */
`timescale 1ns/10ps

module ads_i2c_sva (
	input logic       i2c_clk,
	input logic       i_rst_n,
	input logic       i_scl,
	input logic       i_sda,
	input logic [2:0] i_state,
	input logic       i_done
);

	// engine states 1 and 4 are start and stop
	a_sda_stable: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		($past(i_scl) && i_scl && i_state != 3'd1 && i_state != 3'd4) |-> $stable(i_sda))
		else $error("sda changed while scl high");

	a_done_pulse: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		i_done |=> !i_done)
		else $error("done longer than one cycle");

endmodule

bind i2c_byte_engine ads_i2c_sva u_sva (
	.i2c_clk (i2c_clk),
	.i_rst_n (i_rst_n),
	.i_scl   (io_scl),
	.i_sda   (io_sda),
	.i_state (state),
	.i_done  (o_done)
);

/* ads_i2c_top.sv */
`timescale 1ns/10ps

module ads_i2c_top
	import ads_pkg::*;
(
	input  logic        i2c_clk,
	input  logic        i_rst_n,
	input  logic [6:0]  i_dev_addr,
	input  logic [7:0]  i_reg_addr,
	input  logic [7:0]  i_w_data,
	input  logic [31:0] i_ctrl,
	input  logic        i_drdy,       // active low
	inout  wire         i2c_scl,
	inout  wire         i2c_sda,
	output adc_sample_t o_ain0,
	output adc_sample_t o_ain1,
	output adc_sample_t o_ain2,
	output adc_sample_t o_ain3,
	output reg_byte_t   o_rd_data,
	output ads_status_t o_status
);

	i2c_xfer_t  xfer;
	i2c_rx_t    rx;
	logic       start;
	logic       done;
	logic       eng_nack;
	logic       commit_sample;
	logic       commit_reg;
	logic [1:0] chan;
	logic       ready;
	logic       finish;
	logic       nack;

	ads_cmd_sequencer u_seq (
		.i2c_clk         (i2c_clk),
		.i_rst_n         (i_rst_n),
		.i_ctrl          (i_ctrl),
		.i_dev_addr      (i_dev_addr),
		.i_reg_addr      (i_reg_addr),
		.i_w_data        (i_w_data),
		.i_drdy          (i_drdy),
		.i_done          (done),
		.i_nack          (eng_nack),
		.o_xfer          (xfer),
		.o_start         (start),
		.o_commit_sample (commit_sample),
		.o_commit_reg    (commit_reg),
		.o_chan          (chan),
		.o_ready         (ready),
		.o_nack          (nack)
	);

	i2c_byte_engine u_eng (
		.i2c_clk (i2c_clk),
		.i_rst_n (i_rst_n),
		.i_xfer  (xfer),
		.i_start (start),
		.o_done  (done),
		.o_nack  (eng_nack),
		.o_rx    (rx),
		.io_scl  (i2c_scl),
		.io_sda  (i2c_sda)
	);

	ads_result_bank u_bank (
		.i2c_clk         (i2c_clk),
		.i_rst_n         (i_rst_n),
		.i_rx            (rx),
		.i_commit_sample (commit_sample),
		.i_commit_reg    (commit_reg),
		.i_chan          (chan),
		.o_ain0          (o_ain0),
		.o_ain1          (o_ain1),
		.o_ain2          (o_ain2),
		.o_ain3          (o_ain3),
		.o_rd_data       (o_rd_data),
		.o_finish        (finish)
	);

	assign o_status = '{ready: ready, finish: finish, nack: nack};

endmodule

/* ads_macros.svh */
`ifndef ADS_MACROS_SVH
`define ADS_MACROS_SVH

// ADS122C04 command bytes
`define ADS_CFG0_WREG 8'h40
`define ADS_CMD_START 8'h08
`define ADS_CMD_RDATA 8'h10

// input mux for AINn vs AVSS: base + n * step
`define ADS_MUX_BASE 8'h81
`define ADS_MUX_STEP 8'h10

// control word layout
`define ADS_CTRL_EN_BIT   0
`define ADS_CTRL_MODE_LSB 1

// i2c_clk cycles per quarter of an SCL bit
`define I2C_QTR_CYCLES 1

// bytes per conversion result
`define ADS_SAMPLE_BYTES 3

`endif

/* ads_pkg.sv */
package ads_pkg;

	// operating mode, ctrl bits 3:1
	typedef enum logic [2:0] {
		MODE_CPU_WR  = 3'd0,
		MODE_CPU_RD  = 3'd1,
		MODE_HW_SCAN = 3'd2
	} ads_mode_e;

	// one I2C transfer from start to stop
	typedef struct packed {
		logic [6:0] dev_addr;
		logic       rw;        // 1 = read
		logic [7:0] cmd;       // register or command byte, writes only
		logic [7:0] data;
		logic       has_data;  // send data after cmd
		logic [1:0] rd_cnt;    // bytes to read
	} i2c_xfer_t;

	typedef struct packed {
		logic       valid;     // one cycle per received byte
		logic [7:0] data;
	} i2c_rx_t;

	typedef struct packed {
		logic ready;
		logic finish;
		logic nack;
	} ads_status_t;

	typedef logic [23:0] adc_sample_t;  // msb first on the bus
	typedef logic [7:0]  reg_byte_t;

endpackage

/* ads_result_bank.sv */
`timescale 1ns/10ps

module ads_result_bank
	import ads_pkg::*;
(
	input  logic        i2c_clk,
	input  logic        i_rst_n,
	input  i2c_rx_t     i_rx,
	input  logic        i_commit_sample,
	input  logic        i_commit_reg,
	input  logic [1:0]  i_chan,
	output adc_sample_t o_ain0,
	output adc_sample_t o_ain1,
	output adc_sample_t o_ain2,
	output adc_sample_t o_ain3,
	output reg_byte_t   o_rd_data,
	output logic        o_finish
);

	adc_sample_t ain [4];

	// one sample register per channel, only the addressed one publishes
	for (genvar n = 0; n < 4; n++) begin : g_chan
		ads_capture #(.T(adc_sample_t)) u_sample_cap (
			.i2c_clk  (i2c_clk),
			.i_rst_n  (i_rst_n),
			.i_rx     (i_rx),
			.i_commit (i_commit_sample && (i_chan == 2'(n))),
			.o_value  (ain[n])
		);
	end

	ads_capture #(.T(reg_byte_t)) u_reg_cap (
		.i2c_clk  (i2c_clk),
		.i_rst_n  (i_rst_n),
		.i_rx     (i_rx),
		.i_commit (i_commit_reg),
		.o_value  (o_rd_data)
	);

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_finish <= 1'b0;
		else
			o_finish <= i_commit_sample || i_commit_reg;  // lines up with the outputs
	end

	assign o_ain0 = ain[0];
	assign o_ain1 = ain[1];
	assign o_ain2 = ain[2];
	assign o_ain3 = ain[3];

endmodule

/* i2c_byte_engine.sv */
`timescale 1ns/10ps
`include "ads_macros.svh"

module i2c_byte_engine
	import ads_pkg::*;
(
	input  logic      i2c_clk,
	input  logic      i_rst_n,
	input  i2c_xfer_t i_xfer,
	input  logic      i_start,
	output logic      o_done,
	output logic      o_nack,
	output i2c_rx_t   o_rx,
	inout  wire       io_scl,
	inout  wire       io_sda
);

	localparam int QTR = `I2C_QTR_CYCLES;

	typedef enum logic [2:0] {
		ST_IDLE, ST_START, ST_WRITE, ST_READ, ST_STOP
	} eng_st_e;

	eng_st_e    state;
	i2c_xfer_t  xfer;
	logic [7:0] shreg;     // tx byte msb first, or rx byte
	logic [7:0] qtr_cnt;
	logic [1:0] phase;     // quarter of the bit, scl low in 0 and 1
	logic [3:0] bit_cnt;   // 8 is the ack slot
	logic [1:0] byte_cnt;
	logic       sda_low;
	logic       scl_low;
	logic       rx_valid;
	logic       tick;
	logic       bit_end;
	logic       ack_slot;
	logic       last_rd;
	logic       load_cmd;
	logic       load_data;

	assign tick      = (state != ST_IDLE) && (qtr_cnt == 8'(QTR - 1));
	assign bit_end   = tick && (phase == 2'd3);
	assign ack_slot  = (bit_cnt == 4'd8);
	assign last_rd   = (byte_cnt == xfer.rd_cnt - 2'd1);
	assign load_cmd  = bit_end && state == ST_WRITE && ack_slot && !o_nack
		&& byte_cnt == 2'd0 && !xfer.rw;
	assign load_data = bit_end && state == ST_WRITE && ack_slot && !o_nack
		&& byte_cnt == 2'd1 && xfer.has_data;
	assign scl_low   = (state == ST_WRITE || state == ST_READ || state == ST_STOP) && !phase[1];

	// open drain, pull low or release
	assign io_scl = scl_low ? 1'b0 : 1'bz;
	assign io_sda = sda_low ? 1'b0 : 1'bz;
	assign o_rx   = '{valid: rx_valid, data: shreg};

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= ST_IDLE;
			qtr_cnt  <= '0;
			phase    <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			sda_low  <= 1'b0;
			rx_valid <= 1'b0;
			o_done   <= 1'b0;
			o_nack   <= 1'b0;
		end else begin
			o_done   <= 1'b0;
			rx_valid <= 1'b0;
			qtr_cnt  <= (state == ST_IDLE || tick) ? 8'd0 : qtr_cnt + 8'd1;
			if (tick)
				phase <= phase + 2'd1;
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state  <= ST_START;
						phase  <= '0;
						o_nack <= 1'b0;
					end
				end
				ST_START: begin
					if (tick && phase == 2'd1)
						sda_low <= 1'b1;  // sda falls with scl high
					if (bit_end) begin
						state    <= ST_WRITE;
						bit_cnt  <= '0;
						byte_cnt <= '0;
					end
				end
				ST_WRITE: begin
					if (tick && phase == 2'd0)
						sda_low <= ack_slot ? 1'b0 : !shreg[7];
					if (tick && phase == 2'd2 && ack_slot && io_sda)
						o_nack <= 1'b1;  // slave left sda high
					if (bit_end && !ack_slot) begin
						bit_cnt <= bit_cnt + 4'd1;
					end else if (bit_end) begin
						bit_cnt <= '0;
						if (o_nack)
							state <= ST_STOP;
						else if (load_cmd || load_data)
							byte_cnt <= byte_cnt + 2'd1;
						else if (byte_cnt == 2'd0)
							state <= ST_READ;  // address acked, read transfer
						else
							state <= ST_STOP;
					end
				end
				ST_READ: begin
					if (tick && phase == 2'd0)
						sda_low <= ack_slot && !last_rd;  // nack the last byte
					if (bit_end && !ack_slot) begin
						bit_cnt  <= bit_cnt + 4'd1;
						rx_valid <= (bit_cnt == 4'd7);
					end else if (bit_end && last_rd) begin
						state <= ST_STOP;
					end else if (bit_end) begin
						bit_cnt  <= '0;
						byte_cnt <= byte_cnt + 2'd1;
					end
				end
				ST_STOP: begin
					if (tick && phase == 2'd0)
						sda_low <= 1'b1;
					if (tick && phase == 2'd2)
						sda_low <= 1'b0;  // sda rises with scl high
					if (bit_end) begin
						state  <= ST_IDLE;
						o_done <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// descriptor and shift register
	always_ff @(posedge i2c_clk) begin
		if (state == ST_IDLE && i_start) begin
			xfer  <= i_xfer;
			shreg <= {i_xfer.dev_addr, i_xfer.rw};
		end else if (load_cmd) begin
			shreg <= xfer.cmd;
		end else if (load_data) begin
			shreg <= xfer.data;
		end else if (state == ST_READ && tick && phase == 2'd2 && !ack_slot) begin
			shreg <= {shreg[6:0], io_sda};  // sample mid scl high
		end else if (state == ST_WRITE && bit_end && !ack_slot) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ads_i2c -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

/* tb_ads_i2c.sv */
`timescale 1ns/10ps

module tb_ads_i2c
	import ads_pkg::*;
;

	// one stimulus row with its expected results
	typedef struct packed {
		ads_mode_e  mode;
		logic [6:0] dev;
		logic [7:0] reg_addr;
		logic [7:0] data;
		logic [7:0] ret;       // byte the slave returns on a register read
		logic       exp_nack;
	} row_t;

	localparam int NROWS     = 5;
	localparam int DRDY_HOLD = 120;                // cycles the conversion stays busy
	localparam int SCAN_NS   = 4 * 150 * 4 * 40;  // four channels, about 150 bits each
	localparam int LIMIT     = NROWS * SCAN_NS * 2;

	logic        i2c_clk = 1'b0;
	logic        i_rst_n;
	logic [6:0]  i_dev_addr;
	logic [7:0]  i_reg_addr;
	logic [7:0]  i_w_data;
	logic [31:0] i_ctrl;
	logic        i_drdy;
	wire         scl;
	wire         sda;
	adc_sample_t o_ain0;
	adc_sample_t o_ain1;
	adc_sample_t o_ain2;
	adc_sample_t o_ain3;
	reg_byte_t   o_rd_data;
	ads_status_t o_status;

	row_t        table_rows [NROWS];
	logic [7:0]  mux_exp [4] = '{8'h81, 8'h91, 8'ha1, 8'hb1};  // CONFIG_0 for AIN0..AIN3
	int          errors = 0;
	int          fin_cnt = 0;

	// ADC slave model state
	logic [7:0]  wr_bytes [$];
	logic [7:0]  rd_ret [3];
	logic [7:0]  shreg;
	logic        sda_drv = 1'b0;
	logic        active = 1'b0;
	logic        addressed = 1'b0;
	logic        reading = 1'b0;
	int          bitn = 0;
	int          byten = 0;
	int          rd_idx = 0;
	int          wr_at_read = -1;

	pullup (scl);
	pullup (sda);
	assign sda = sda_drv ? 1'b0 : 1'bz;

	ads_i2c_top UUT (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_dev_addr (i_dev_addr),
		.i_reg_addr (i_reg_addr),
		.i_w_data   (i_w_data),
		.i_ctrl     (i_ctrl),
		.i_drdy     (i_drdy),
		.i2c_scl    (scl),
		.i2c_sda    (sda),
		.o_ain0     (o_ain0),
		.o_ain1     (o_ain1),
		.o_ain2     (o_ain2),
		.o_ain3     (o_ain3),
		.o_rd_data  (o_rd_data),
		.o_status   (o_status)
	);

	always #20 i2c_clk = ~i2c_clk;

	always @(posedge i2c_clk)
		if (o_status.finish)
			fin_cnt++;

	always @(negedge sda) begin
		if (scl) begin  // start condition
			active    = 1'b1;
			addressed = 1'b0;
			reading   = 1'b0;
			bitn      = 0;
			byten     = 0;
			rd_idx    = 0;
			sda_drv   = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl) begin  // stop condition
			active  = 1'b0;
			sda_drv = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			if (bitn < 8) begin
				if (!reading)
					shreg = {shreg[6:0], sda};
				bitn++;
			end else begin
				if (reading) begin
					if (sda)
						reading = 1'b0;  // master nack ends the read
					else
						rd_idx++;
				end else begin
					if (byten == 0 && addressed)
						reading = shreg[0];
					byten++;
				end
				bitn = 0;
			end
		end
	end

	always @(negedge scl) begin
		if (active) begin
			if (bitn == 8 && !reading) begin
				if (byten == 0) begin
					addressed = (shreg[7:1] == 7'h40);
					if (addressed && shreg[0])
						wr_at_read = wr_bytes.size();
					sda_drv = addressed;
				end else begin
					if (addressed)
						wr_bytes.push_back(shreg);
					sda_drv = addressed;
				end
			end else if (bitn < 8 && reading) begin
				sda_drv = !rd_ret[rd_idx][7 - bitn];
			end else begin
				sda_drv = 1'b0;
			end
		end
	end

	task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
		assert (got == exp) else begin
			$display("error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic adc_sample_t ain_of(int ch);
		case (ch)
			0: return o_ain0;
			1: return o_ain1;
			2: return o_ain2;
			default: return o_ain3;
		endcase
	endfunction

	// raise enable and wait for the sequencer to go busy and come back
	task automatic run_op(row_t r);
		@(negedge i2c_clk);
		i_dev_addr = r.dev;
		i_reg_addr = r.reg_addr;
		i_w_data   = r.data;
		i_ctrl     = {28'd0, r.mode, 1'b1};
		while (o_status.ready)
			@(posedge i2c_clk);
		while (!o_status.ready)
			@(posedge i2c_clk);
		repeat (2) @(posedge i2c_clk);  // finish trails the commit
		@(negedge i2c_clk);
		i_ctrl[0] = 1'b0;
	endtask

	task automatic run_scan(row_t r);
		adc_sample_t smp;
		int          fin0;
		@(negedge i2c_clk);
		i_dev_addr = r.dev;
		i_ctrl     = {28'd0, r.mode, 1'b1};
		for (int ch = 0; ch < 4; ch++) begin
			smp = adc_sample_t'($urandom);
			rd_ret[0] = smp[23:16];
			rd_ret[1] = smp[15:8];
			rd_ret[2] = smp[7:0];
			fin0 = fin_cnt;
			while (wr_bytes.size() < 3)
				@(posedge i2c_clk);
			repeat (DRDY_HOLD) @(negedge i2c_clk);  // conversion still running
			check_val("bytes before drdy", wr_bytes.size(), 3);
			if (ch == 3)
				i_ctrl[0] = 1'b0;  // stop the loop after this channel
			i_drdy = 1'b0;
			while (wr_bytes.size() < 4)
				@(posedge i2c_clk);
			@(negedge i2c_clk);
			i_drdy = 1'b1;
			while (fin_cnt == fin0)
				@(posedge i2c_clk);
			@(negedge i2c_clk);
			check_val("cfg0 wreg", wr_bytes[0], 8'h40);
			check_val("mux byte", wr_bytes[1], mux_exp[ch]);
			check_val("start cmd", wr_bytes[2], 8'h08);
			check_val("rdata cmd", wr_bytes[3], 8'h10);
			check_val($sformatf("o_ain%0d", ch), ain_of(ch), smp);
			wr_bytes.delete();
		end
		while (!o_status.ready)
			@(posedge i2c_clk);
	endtask

	initial begin
		#(LIMIT);
		$display("watchdog: run did not finish in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		int   err0;
		int   fin0;
		row_t r;
		void'($urandom(32564));
		table_rows[0] = '{MODE_CPU_WR, 7'h40, 8'h44, 8'h5a, 8'h00, 1'b0};
		table_rows[1] = '{MODE_CPU_RD, 7'h40, 8'h24, 8'h00, 8'hc3, 1'b0};
		table_rows[2] = '{MODE_HW_SCAN, 7'h40, 8'h00, 8'h00, 8'h00, 1'b0};
		table_rows[3] = '{MODE_CPU_WR, 7'h22, 8'h44, 8'h11, 8'h00, 1'b1};
		table_rows[4] = '{MODE_CPU_RD, 7'h40, 8'h28, 8'h00, 8'h7e, 1'b0};
		i_rst_n    = 1'b0;
		i_dev_addr = '0;
		i_reg_addr = '0;
		i_w_data   = '0;
		i_ctrl     = '0;
		i_drdy     = 1'b1;
		repeat (2) @(posedge i2c_clk);
		@(negedge i2c_clk);
		i_rst_n = 1'b1;
		@(negedge i2c_clk);
		check_val("scl", scl, 1);
		check_val("sda", sda, 1);
		check_val("o_status", o_status, 3'b100);
		check_val("o_ain0", o_ain0, 0);
		check_val("o_ain1", o_ain1, 0);
		check_val("o_ain2", o_ain2, 0);
		check_val("o_ain3", o_ain3, 0);
		$display("test reset: %s", errors == 0 ? "ok" : "FAIL");
		for (int i = 0; i < NROWS; i++) begin
			r    = table_rows[i];
			err0 = errors;
			fin0 = fin_cnt;
			wr_bytes.delete();
			wr_at_read = -1;
			rd_ret[0]  = r.ret;
			if (r.mode == MODE_HW_SCAN) begin
				run_scan(r);
			end else begin
				run_op(r);
				check_val("o_status.nack", o_status.nack, r.exp_nack);
				check_val("o_status.ready", o_status.ready, 1);
				if (r.exp_nack) begin
					check_val("slave byte count", wr_bytes.size(), 0);
				end else if (r.mode == MODE_CPU_WR) begin
					check_val("slave byte count", wr_bytes.size(), 2);
					check_val("slave reg byte", wr_bytes[0], r.reg_addr);
					check_val("slave data byte", wr_bytes[1], r.data);
					check_val("finish pulses", fin_cnt - fin0, 1);
				end else begin
					check_val("slave byte count", wr_bytes.size(), 1);
					check_val("slave reg byte", wr_bytes[0], r.reg_addr);
					check_val("writes before read", wr_at_read, 1);
					check_val("o_rd_data", o_rd_data, r.ret);
				end
			end
			$display("test %0d mode %0d: %s", i, r.mode, errors == err0 ? "ok" : "FAIL");
		end
		$display("%0d tests, %0d errors", NROWS + 1, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
ads_pkg.sv
ads_capture.sv
ads_result_bank.sv
ads_cmd_sequencer.sv
i2c_byte_engine.sv
ads_i2c_top.sv
ads_i2c_sva.sv
tb_ads_i2c.sv
